// File: vlog.f
source/soc_pkg.sv
source/bus_if.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/write_buffer.sv
source/block_ram.sv
source/io_bridge.sv
source/system_registers.sv
source/soc_fabric.sv
bench/tb_soc_fabric.sv

// File: run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, then search the log for the fail message

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_soc_fabric -o tb_soc_fabric \
	&& ./obj_dir/tb_soc_fabric 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }

grep -q "Finished with errors" sim.log \
	&& { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// File: bench/tb_soc_fabric.sv
module tb_soc_fabric;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RAM_WORDS = int'(soc_pkg::RAM_BYTES / 4);
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int POOL_WORDS = 64;

	// Word pools, one per port, so concurrent traffic never shares an address
	localparam int INSTR_POOL = 0;
	localparam int DATA_POOL = 64;
	localparam int DMA_POOL = 128;

	localparam soc_pkg::addr_t SYSREG_BASE = {soc_pkg::REGION_BRIDGE, soc_pkg::DEVICE_SYSREG, 24'h0};

	logic clock;
	logic reset;
	logic ibus_request;
	soc_pkg::addr_t ibus_address;
	logic ibus_ready;
	soc_pkg::word_t ibus_rdata;
	logic dbus_request;
	logic dbus_rw;
	soc_pkg::addr_t dbus_address;
	soc_pkg::word_t dbus_wdata;
	logic dbus_ready;
	soc_pkg::word_t dbus_rdata;
	logic dma_request;
	logic dma_rw;
	soc_pkg::addr_t dma_address;
	soc_pkg::word_t dma_wdata;
	logic dma_ready;
	soc_pkg::word_t dma_rdata;
	logic [soc_pkg::LED_WIDTH-1:0] leds;
	logic bus_fault;
	soc_pkg::addr_t fault_address;
	soc_pkg::master_e fault_master;

	// Memory model, keyed by byte address
	soc_pkg::word_t ram_model [soc_pkg::addr_t];
	logic ibus_waiting;
	logic dbus_waiting;
	logic dma_waiting;
	logic fault_expected;
	soc_pkg::addr_t expected_fault_address;
	soc_pkg::master_e expected_fault_master;
	int fault_count;

	soc_fabric dut0 (
		.clock(clock),
		.i_reset(reset),
		.i_ibus_request(ibus_request),
		.i_ibus_address(ibus_address),
		.o_ibus_ready(ibus_ready),
		.o_ibus_rdata(ibus_rdata),
		.i_dbus_request(dbus_request),
		.i_dbus_rw(dbus_rw),
		.i_dbus_address(dbus_address),
		.i_dbus_wdata(dbus_wdata),
		.o_dbus_ready(dbus_ready),
		.o_dbus_rdata(dbus_rdata),
		.i_dma_request(dma_request),
		.i_dma_rw(dma_rw),
		.i_dma_address(dma_address),
		.i_dma_wdata(dma_wdata),
		.o_dma_ready(dma_ready),
		.o_dma_rdata(dma_rdata),
		.o_leds(leds),
		.o_bus_fault(bus_fault),
		.o_fault_address(fault_address),
		.o_fault_master(fault_master)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input soc_pkg::word_t got,
			input soc_pkg::word_t expected);
		assert (got === expected)
		else report_failure($sformatf("Error: %s expected %h got %h", name, expected, got));
	endtask

	function automatic string rdata_name(input soc_pkg::master_e port);
		case (port)
			soc_pkg::MASTER_INSTRUCTION: return "o_ibus_rdata";
			soc_pkg::MASTER_DATA: return "o_dbus_rdata";
			default: return "o_dma_rdata";
		endcase
	endfunction

	// Random word inside a port's pool
	function automatic soc_pkg::addr_t ram_address(input int base);
		int index;
		index = (base + int'($urandom_range(POOL_WORDS - 1))) % RAM_WORDS;
		return {soc_pkg::REGION_RAM, 28'(index * 4)};
	endfunction

	//======================================================================
	// Master driver
	//======================================================================

	// Called at a falling edge, returns at the falling edge that drops request
	task automatic bus_access(input soc_pkg::master_e port, input logic rw,
			input soc_pkg::addr_t address, input soc_pkg::word_t wdata,
			output soc_pkg::word_t rdata);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		rdata = '0;
		case (port)
			soc_pkg::MASTER_INSTRUCTION: begin
				ibus_address = address;
				ibus_request = 1'b1;
				ibus_waiting = 1'b1;
			end
			soc_pkg::MASTER_DATA: begin
				dbus_rw = rw;
				dbus_address = address;
				dbus_wdata = wdata;
				dbus_request = 1'b1;
				dbus_waiting = 1'b1;
			end
			default: begin
				dma_rw = rw;
				dma_address = address;
				dma_wdata = wdata;
				dma_request = 1'b1;
				dma_waiting = 1'b1;
			end
		endcase
		while (!done) begin
			@(negedge clock);
			cycles++;
			case (port)
				soc_pkg::MASTER_INSTRUCTION: begin
					done = ibus_ready;
					rdata = ibus_rdata;
				end
				soc_pkg::MASTER_DATA: begin
					done = dbus_ready;
					rdata = dbus_rdata;
				end
				default: begin
					done = dma_ready;
					rdata = dma_rdata;
				end
			endcase
			if (!done && cycles >= TIMEOUT_CYCLES)
				report_failure($sformatf("Timeout waiting for ready on port %s", port.name()));
		end
		ibus_waiting = (port == soc_pkg::MASTER_INSTRUCTION) ? 1'b0 : ibus_waiting;
		dbus_waiting = (port == soc_pkg::MASTER_DATA) ? 1'b0 : dbus_waiting;
		dma_waiting = (port == soc_pkg::MASTER_DMA) ? 1'b0 : dma_waiting;
		// Request stays up across the edge that ends the ready cycle
		@(negedge clock);
		case (port)
			soc_pkg::MASTER_INSTRUCTION: ibus_request = 1'b0;
			soc_pkg::MASTER_DATA: dbus_request = 1'b0;
			default: dma_request = 1'b0;
		endcase
	endtask

	task automatic ram_write(input soc_pkg::master_e port, input soc_pkg::addr_t address,
			input soc_pkg::word_t data);
		soc_pkg::word_t rdata;
		bus_access(port, 1'b1, address, data, rdata);
		ram_model[address] = data;
	endtask

	task automatic read_check(input soc_pkg::master_e port, input soc_pkg::addr_t address,
			input soc_pkg::word_t expected);
		soc_pkg::word_t rdata;
		bus_access(port, 1'b0, address, '0, rdata);
		check_word(rdata_name(port), rdata, expected);
	endtask

	//======================================================================
	// Checks on every cycle
	//======================================================================

	assert property (@(negedge clock) disable iff (reset)
		ibus_ready |-> ibus_request && ibus_waiting)
	else report_failure("Instruction port got a ready it was not waiting for");

	assert property (@(negedge clock) disable iff (reset)
		dbus_ready |-> dbus_request && dbus_waiting)
	else report_failure("Data port got a ready it was not waiting for");

	assert property (@(negedge clock) disable iff (reset)
		dma_ready |-> dma_request && dma_waiting)
	else report_failure("DMA port got a ready it was not waiting for");

	assert property (@(negedge clock) disable iff (reset) bus_fault |-> fault_expected)
	else report_failure("Bus fault raised by an access to a mapped address");

	assert property (@(negedge clock) disable iff (reset)
		bus_fault |-> fault_address == expected_fault_address)
	else report_failure($sformatf("Error: o_fault_address expected %h got %h",
		expected_fault_address, fault_address));

	assert property (@(negedge clock) disable iff (reset)
		bus_fault |-> fault_master == expected_fault_master)
	else report_failure($sformatf("Error: o_fault_master expected %h got %h",
		expected_fault_master, fault_master));

	always @(negedge clock)
		if (!reset && bus_fault)
			fault_count <= fault_count + 1;

	//======================================================================
	// Behaviors
	//======================================================================

	task automatic ram_round_trip();
		soc_pkg::addr_t address;
		soc_pkg::master_e reader;
		for (int i = 0; i < 9; i++) begin
			address = ram_address(DATA_POOL);
			reader = soc_pkg::master_e'(1 + i % 3);
			ram_write(soc_pkg::MASTER_DATA, address, $urandom);
			read_check(reader, address, ram_model[address]);
		end
	endtask

	// More writes than the buffer holds, several to one address
	task automatic overwrite_sequence();
		soc_pkg::addr_t targets [3];
		foreach (targets[i])
			targets[i] = ram_address(DATA_POOL);
		for (int i = 0; i < 10; i++)
			ram_write(soc_pkg::MASTER_DATA, targets[$urandom_range(2)], $urandom);
		foreach (targets[i])
			read_check(soc_pkg::MASTER_DATA, targets[i], ram_model[targets[i]]);
	endtask

	task automatic system_register_checks();
		soc_pkg::word_t data;
		soc_pkg::word_t rdata;
		read_check(soc_pkg::MASTER_DATA, SYSREG_BASE, soc_pkg::DEVICE_ID);
		read_check(soc_pkg::MASTER_DMA, SYSREG_BASE + 32'd4, soc_pkg::RAM_BYTES);
		data = $urandom;
		bus_access(soc_pkg::MASTER_DATA, 1'b1, SYSREG_BASE + 32'd8, data, rdata);
		check_word("o_leds", soc_pkg::word_t'(leds),
			soc_pkg::word_t'(data[soc_pkg::LED_WIDTH-1:0]));
		data = $urandom;
		bus_access(soc_pkg::MASTER_DMA, 1'b1, SYSREG_BASE + 32'd12, data, rdata);
		read_check(soc_pkg::MASTER_INSTRUCTION, SYSREG_BASE + 32'd12, data);
		// Device ID is read only
		bus_access(soc_pkg::MASTER_DATA, 1'b1, SYSREG_BASE, $urandom, rdata);
		read_check(soc_pkg::MASTER_DATA, SYSREG_BASE, soc_pkg::DEVICE_ID);
	endtask

	task automatic fault_checks();
		soc_pkg::addr_t address;
		soc_pkg::word_t rdata;
		soc_pkg::master_e port;
		logic [3:0] region;
		int faults_before;
		for (int i = 0; i < 6; i++) begin
			port = soc_pkg::master_e'(1 + i % 3);
			region = 4'($urandom_range(15));
			if (region == soc_pkg::REGION_RAM || region == soc_pkg::REGION_BRIDGE)
				region = region + 4'h1;
			address = {region, 28'($urandom)};
			expected_fault_address = address;
			expected_fault_master = port;
			fault_expected = 1'b1;
			faults_before = fault_count;
			bus_access(port, 1'(i % 2), address, $urandom, rdata);
			fault_expected = 1'b0;
			check_word(rdata_name(port), rdata, '0);
			assert (fault_count == faults_before + 1)
			else report_failure($sformatf("Access to %h gave %0d bus faults instead of one",
				address, fault_count - faults_before));
		end
		// Unknown device behind the bridge answers zero without a fault
		faults_before = fault_count;
		address = {soc_pkg::REGION_BRIDGE, 4'h3, 24'($urandom)};
		bus_access(soc_pkg::MASTER_DATA, 1'b0, address, '0, rdata);
		check_word("o_dbus_rdata", rdata, '0);
		assert (fault_count == faults_before)
		else report_failure("Unknown device behind the bridge raised a bus fault");
	endtask

	task automatic master_traffic(input soc_pkg::master_e port, input int base,
			input int count);
		soc_pkg::addr_t address;
		repeat (count) begin
			repeat ($urandom_range(6, 1)) @(negedge clock);
			address = ram_address(base);
			if (port != soc_pkg::MASTER_INSTRUCTION &&
					(!ram_model.exists(address) || $urandom_range(1) == 1))
				ram_write(port, address, $urandom);
			else
				read_check(port, address, ram_model[address]);
		end
	endtask

	initial begin
		void'($urandom(32'h615b_a0c5));
		reset = 1'b1;
		ibus_request = 1'b0;
		ibus_address = '0;
		dbus_request = 1'b0;
		dbus_rw = 1'b0;
		dbus_address = '0;
		dbus_wdata = '0;
		dma_request = 1'b0;
		dma_rw = 1'b0;
		dma_address = '0;
		dma_wdata = '0;
		ibus_waiting = 1'b0;
		dbus_waiting = 1'b0;
		dma_waiting = 1'b0;
		fault_expected = 1'b0;
		expected_fault_address = '0;
		expected_fault_master = soc_pkg::MASTER_NONE;
		fault_count = 0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		assert (!ibus_ready && !dbus_ready && !dma_ready && !bus_fault)
		else report_failure("Ready or fault output high after reset");
		check_word("o_leds", soc_pkg::word_t'(leds), '0);

		ram_round_trip();
		overwrite_sequence();
		system_register_checks();
		fault_checks();

		// Instruction pool must hold data before the instruction port reads it
		for (int i = 0; i < POOL_WORDS; i++)
			ram_write(soc_pkg::MASTER_DATA, {soc_pkg::REGION_RAM, 28'((INSTR_POOL + i) * 4)},
				$urandom);
		fork
			master_traffic(soc_pkg::MASTER_INSTRUCTION, INSTR_POOL, 24);
			master_traffic(soc_pkg::MASTER_DATA, DATA_POOL, 24);
			master_traffic(soc_pkg::MASTER_DMA, DMA_POOL, 24);
		join

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: source/soc_fabric.sv
module soc_fabric #(
	parameter int RAM_WORDS = int'(soc_pkg::RAM_BYTES / 4),
	parameter int BUFFER_DEPTH = 4
) (
	input logic clock,
	input logic i_reset,

	input logic i_ibus_request,
	input soc_pkg::addr_t i_ibus_address,
	output logic o_ibus_ready,
	output soc_pkg::word_t o_ibus_rdata,

	input logic i_dbus_request,
	input logic i_dbus_rw,
	input soc_pkg::addr_t i_dbus_address,
	input soc_pkg::word_t i_dbus_wdata,
	output logic o_dbus_ready,
	output soc_pkg::word_t o_dbus_rdata,

	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_pkg::addr_t i_dma_address,
	input soc_pkg::word_t i_dma_wdata,
	output logic o_dma_ready,
	output soc_pkg::word_t o_dma_rdata,

	output logic [soc_pkg::LED_WIDTH-1:0] o_leds,

	// Bus diagnostics
	output logic o_bus_fault,
	output soc_pkg::addr_t o_fault_address,
	output soc_pkg::master_e o_fault_master
);

	bus_if main_bus();
	bus_if ram_bus();
	bus_if memory_bus();
	bus_if bridge_bus();
	bus_if far_bus();

	soc_pkg::master_e bus_owner;

	//======================================================================
	// Main bus
	//======================================================================

	bus_arbiter arbiter0 (
		.clock(clock),
		.i_reset(i_reset),
		.i_ibus_request(i_ibus_request),
		.i_ibus_address(i_ibus_address),
		.o_ibus_ready(o_ibus_ready),
		.o_ibus_rdata(o_ibus_rdata),
		.i_dbus_request(i_dbus_request),
		.i_dbus_rw(i_dbus_rw),
		.i_dbus_address(i_dbus_address),
		.i_dbus_wdata(i_dbus_wdata),
		.o_dbus_ready(o_dbus_ready),
		.o_dbus_rdata(o_dbus_rdata),
		.i_dma_request(i_dma_request),
		.i_dma_rw(i_dma_rw),
		.i_dma_address(i_dma_address),
		.i_dma_wdata(i_dma_wdata),
		.o_dma_ready(o_dma_ready),
		.o_dma_rdata(o_dma_rdata),
		.bus(main_bus.master),
		.o_bus_owner(bus_owner)
	);

	bus_decoder decoder0 (
		.clock(clock),
		.i_reset(i_reset),
		.main(main_bus.slave),
		.ram(ram_bus.master),
		.bridge(bridge_bus.master),
		.i_bus_owner(bus_owner),
		.o_bus_fault(o_bus_fault),
		.o_fault_address(o_fault_address),
		.o_fault_master(o_fault_master)
	);

	//======================================================================
	// RAM behind the write buffer
	//======================================================================

	write_buffer #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) buffer0 (
		.clock(clock),
		.i_reset(i_reset),
		.host(ram_bus.slave),
		.memory(memory_bus.master)
	);

	block_ram #(
		.RAM_WORDS(RAM_WORDS)
	) ram0 (
		.clock(clock),
		.port(memory_bus.slave)
	);

	//======================================================================
	// IO side
	//======================================================================

	io_bridge bridge0 (
		.clock(clock),
		.i_reset(i_reset),
		.near(bridge_bus.slave),
		.far(far_bus.master)
	);

	system_registers sysreg0 (
		.clock(clock),
		.i_reset(i_reset),
		.regs(far_bus.slave),
		.o_leds(o_leds)
	);

endmodule

// File: source/system_registers.sv
module system_registers (
	input logic clock,
	input logic i_reset,
	bus_if.slave regs,
	output logic [soc_pkg::LED_WIDTH-1:0] o_leds
);

	logic [1:0] offset;
	logic access;
	logic ready;
	soc_pkg::word_t rdata;
	soc_pkg::word_t scratch;

	// Word offset within the block
	assign offset = regs.address[3:2];
	assign access = regs.request && !ready;

	always_ff @(posedge clock) begin
		if (i_reset) begin
			ready <= 1'b0;
			o_leds <= '0;
			scratch <= '0;
		end else begin
			ready <= access;
			if (access && regs.rw) begin
				// Offsets 0 and 1 are read only
				case (offset)
					2'd2: o_leds <= regs.wdata[soc_pkg::LED_WIDTH-1:0];
					2'd3: scratch <= regs.wdata;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (offset)
				2'd0: rdata <= soc_pkg::DEVICE_ID;
				2'd1: rdata <= soc_pkg::RAM_BYTES;
				2'd2: rdata <= soc_pkg::word_t'(o_leds);
				default: rdata <= scratch;
			endcase
		end
	end

	assign regs.ready = ready;
	assign regs.rdata = rdata;

endmodule

// File: source/io_bridge.sv
module io_bridge (
	input logic clock,
	input logic i_reset,
	bus_if.slave near,
	bus_if.master far
);

	logic far_active;
	logic far_rw;
	soc_pkg::addr_t far_address;
	soc_pkg::word_t far_wdata;
	logic device_select;
	logic unknown_ready;
	logic far_done;
	soc_pkg::word_t far_result;
	logic near_ready;
	soc_pkg::word_t near_rdata;

	// Device nibble of the registered access
	assign device_select = far_address[27:24] == soc_pkg::DEVICE_SYSREG;

	// Unknown devices answer themselves with zero
	assign far_done = device_select ? far.ready : unknown_ready;
	assign far_result = device_select ? far.rdata : '0;

	always_ff @(posedge clock) begin
		if (i_reset) begin
			far_active <= 1'b0;
			unknown_ready <= 1'b0;
			near_ready <= 1'b0;
		end else begin
			near_ready <= far_active && far_done;
			unknown_ready <= far_active && !device_select && !unknown_ready;
			if (near.request && !far_active && !near_ready)
				far_active <= 1'b1;
			else if (far_done)
				far_active <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (near.request && !far_active && !near_ready) begin
			far_rw <= near.rw;
			far_address <= near.address;
			far_wdata <= near.wdata;
		end
		if (far_active && far_done)
			near_rdata <= far_result;
	end

	assign far.request = far_active && device_select;
	assign far.rw = far_rw;
	assign far.address = far_address;
	assign far.wdata = far_wdata;
	assign near.ready = near_ready;
	assign near.rdata = near_rdata;

endmodule

// File: source/block_ram.sv
module block_ram #(
	parameter int RAM_WORDS = 1024
) (
	input logic clock,
	bus_if.slave port
);

	localparam int INDEX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	soc_pkg::word_t memory [RAM_WORDS];
	logic [INDEX_W-1:0] index;
	logic ready;
	soc_pkg::word_t rdata;

	// Byte address to word index
	assign index = port.address[INDEX_W+1:2];

	always_ff @(posedge clock) begin
		ready <= port.request && !ready;
		if (port.request && !ready) begin
			if (port.rw)
				memory[index] <= port.wdata;
			rdata <= memory[index];
		end
	end

	assign port.ready = ready;
	assign port.rdata = rdata;

endmodule

// File: source/write_buffer.sv
module write_buffer #(
	parameter int BUFFER_DEPTH = 4
) (
	input logic clock,
	input logic i_reset,
	bus_if.slave host,
	bus_if.master memory
);

	localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int COUNT_W = $clog2(BUFFER_DEPTH + 1);

	soc_pkg::addr_t queue_address [BUFFER_DEPTH];
	soc_pkg::word_t queue_data [BUFFER_DEPTH];
	logic [PTR_W-1:0] write_ptr;
	logic [PTR_W-1:0] read_ptr;
	logic [COUNT_W-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;
	logic issue_write;
	logic issue_read;
	logic read_done;
	logic host_ready;
	soc_pkg::word_t host_rdata;
	logic mem_busy;
	logic mem_rw;
	soc_pkg::addr_t mem_address;
	soc_pkg::word_t mem_wdata;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = count == COUNT_W'(BUFFER_DEPTH);
	assign empty = count == '0;
	assign push = host.request && host.rw && !host_ready && !full;
	assign pop = mem_busy && mem_rw && memory.ready;
	assign read_done = mem_busy && !mem_rw && memory.ready;

	// Drain first; a read only goes out with the queue empty
	assign issue_write = !mem_busy && !empty;
	assign issue_read = !mem_busy && empty && host.request && !host.rw && !host_ready;

	always_ff @(posedge clock) begin
		if (i_reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
			mem_busy <= 1'b0;
			host_ready <= 1'b0;
		end else begin
			host_ready <= push || read_done;
			if (push)
				write_ptr <= next_ptr(write_ptr);
			if (pop)
				read_ptr <= next_ptr(read_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			if (issue_write || issue_read)
				mem_busy <= 1'b1;
			else if (mem_busy && memory.ready)
				mem_busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			queue_address[write_ptr] <= host.address;
			queue_data[write_ptr] <= host.wdata;
		end
		if (issue_write) begin
			mem_rw <= 1'b1;
			mem_address <= queue_address[read_ptr];
			mem_wdata <= queue_data[read_ptr];
		end else if (issue_read) begin
			mem_rw <= 1'b0;
			mem_address <= host.address;
		end
		if (read_done)
			host_rdata <= memory.rdata;
	end

	assign memory.request = mem_busy;
	assign memory.rw = mem_rw;
	assign memory.address = mem_address;
	assign memory.wdata = mem_wdata;
	assign host.ready = host_ready;
	assign host.rdata = host_rdata;

	// Queue never holds more entries than its depth
	assert property (@(posedge clock) disable iff (i_reset) count <= COUNT_W'(BUFFER_DEPTH));

	// Reads must never overtake a posted write
	assert property (@(posedge clock) disable iff (i_reset)
		memory.request && !memory.rw |-> empty);

endmodule

// File: source/bus_decoder.sv
module bus_decoder (
	input logic clock,
	input logic i_reset,
	bus_if.slave main,
	bus_if.master ram,
	bus_if.master bridge,
	input soc_pkg::master_e i_bus_owner,
	output logic o_bus_fault,
	output soc_pkg::addr_t o_fault_address,
	output soc_pkg::master_e o_fault_master
);

	logic [3:0] region;
	logic ram_select;
	logic bridge_select;
	logic unmapped;

	assign region = main.address[31:28];
	assign ram_select = region == soc_pkg::REGION_RAM;
	assign bridge_select = region == soc_pkg::REGION_BRIDGE;
	assign unmapped = main.request && !ram_select && !bridge_select;

	// Region nibble stripped on the way down
	assign ram.request = main.request && ram_select;
	assign ram.rw = main.rw;
	assign ram.address = {4'h0, main.address[27:0]};
	assign ram.wdata = main.wdata;

	assign bridge.request = main.request && bridge_select;
	assign bridge.rw = main.rw;
	assign bridge.address = {4'h0, main.address[27:0]};
	assign bridge.wdata = main.wdata;

	// Fault responder, completes an unmapped access one cycle later
	always_ff @(posedge clock) begin
		if (i_reset)
			o_bus_fault <= 1'b0;
		else
			o_bus_fault <= unmapped && !o_bus_fault;
	end

	always_ff @(posedge clock) begin
		if (unmapped && !o_bus_fault) begin
			o_fault_address <= main.address;
			o_fault_master <= i_bus_owner;
		end
	end

	assign main.ready = ram_select ? ram.ready : bridge_select ? bridge.ready : o_bus_fault;
	assign main.rdata = ram_select ? ram.rdata : bridge_select ? bridge.rdata : '0;

	// Only one responder answers in a cycle
	assert property (@(posedge clock) disable iff (i_reset)
		!(ram.ready && bridge.ready) && !(o_bus_fault && (ram.ready || bridge.ready)));

endmodule

// File: source/bus_arbiter.sv
module bus_arbiter (
	input logic clock,
	input logic i_reset,

	// Instruction port, read only
	input logic i_ibus_request,
	input soc_pkg::addr_t i_ibus_address,
	output logic o_ibus_ready,
	output soc_pkg::word_t o_ibus_rdata,

	// Data port
	input logic i_dbus_request,
	input logic i_dbus_rw,
	input soc_pkg::addr_t i_dbus_address,
	input soc_pkg::word_t i_dbus_wdata,
	output logic o_dbus_ready,
	output soc_pkg::word_t o_dbus_rdata,

	// DMA port
	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_pkg::addr_t i_dma_address,
	input soc_pkg::word_t i_dma_wdata,
	output logic o_dma_ready,
	output soc_pkg::word_t o_dma_rdata,

	bus_if.master bus,
	output soc_pkg::master_e o_bus_owner
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUS,
		ARB_RESPOND
	} arb_state_e;

	arb_state_e state;
	soc_pkg::master_e grant;
	soc_pkg::master_e pick;
	logic bus_request;
	logic bus_rw;
	soc_pkg::addr_t bus_address;
	soc_pkg::word_t bus_wdata;
	soc_pkg::word_t response_rdata;

	// Fixed priority: instruction, data, DMA
	always_comb begin
		pick = soc_pkg::MASTER_NONE;
		if (i_ibus_request)
			pick = soc_pkg::MASTER_INSTRUCTION;
		else if (i_dbus_request)
			pick = soc_pkg::MASTER_DATA;
		else if (i_dma_request)
			pick = soc_pkg::MASTER_DMA;
	end

	always_ff @(posedge clock) begin
		if (i_reset) begin
			state <= ARB_IDLE;
			grant <= soc_pkg::MASTER_NONE;
			bus_request <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick != soc_pkg::MASTER_NONE) begin
						grant <= pick;
						bus_request <= 1'b1;
						state <= ARB_BUS;
					end
				end
				ARB_BUS: begin
					if (bus.ready) begin
						bus_request <= 1'b0;
						state <= ARB_RESPOND;
					end
				end
				// Port sees its ready here, so no regrant this cycle
				ARB_RESPOND: begin
					grant <= soc_pkg::MASTER_NONE;
					state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Latched fields of the granted port
	always_ff @(posedge clock) begin
		if (state == ARB_IDLE) begin
			case (pick)
				soc_pkg::MASTER_INSTRUCTION: begin
					bus_rw <= 1'b0;
					bus_address <= i_ibus_address;
					bus_wdata <= '0;
				end
				soc_pkg::MASTER_DATA: begin
					bus_rw <= i_dbus_rw;
					bus_address <= i_dbus_address;
					bus_wdata <= i_dbus_wdata;
				end
				soc_pkg::MASTER_DMA: begin
					bus_rw <= i_dma_rw;
					bus_address <= i_dma_address;
					bus_wdata <= i_dma_wdata;
				end
				default: ;
			endcase
		end
		if (state == ARB_BUS && bus.ready)
			response_rdata <= bus.rdata;
	end

	assign bus.request = bus_request;
	assign bus.rw = bus_rw;
	assign bus.address = bus_address;
	assign bus.wdata = bus_wdata;
	assign o_bus_owner = grant;

	assign o_ibus_ready = state == ARB_RESPOND && grant == soc_pkg::MASTER_INSTRUCTION;
	assign o_dbus_ready = state == ARB_RESPOND && grant == soc_pkg::MASTER_DATA;
	assign o_dma_ready = state == ARB_RESPOND && grant == soc_pkg::MASTER_DMA;
	assign o_ibus_rdata = response_rdata;
	assign o_dbus_rdata = response_rdata;
	assign o_dma_rdata = response_rdata;

	// A port only gets ready while it still holds its request
	assert property (@(posedge clock) disable iff (i_reset) o_ibus_ready |-> i_ibus_request);
	assert property (@(posedge clock) disable iff (i_reset) o_dbus_ready |-> i_dbus_request);
	assert property (@(posedge clock) disable iff (i_reset) o_dma_ready |-> i_dma_request);

	// Request and its fields held until ready
	assert property (@(posedge clock) disable iff (i_reset)
		bus.request && !bus.ready |=> bus.request && $stable(bus.address)
			&& $stable(bus.rw) && $stable(bus.wdata));

endmodule

// File: source/bus_if.sv
interface bus_if;

	logic request;
	logic rw;
	soc_pkg::addr_t address;
	soc_pkg::word_t wdata;
	soc_pkg::word_t rdata;
	logic ready;

	// Requesting side, holds request until ready
	modport master(
		output request, rw, address, wdata,
		input rdata, ready
	);

	// Responding side, ready is a one-cycle pulse
	modport slave(
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

// File: source/soc_pkg.sv
package soc_pkg;

	//======================================================================
	// Bus payload types
	//======================================================================

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// Current bus owner, also names the source of a fault
	typedef enum logic [1:0] {
		MASTER_NONE,
		MASTER_INSTRUCTION,
		MASTER_DATA,
		MASTER_DMA
	} master_e;

	//======================================================================
	// Address map
	//======================================================================

	// Top address nibble on the main bus
	localparam logic [3:0] REGION_RAM = 4'h2;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	// Device nibble, bits 27:24, behind the IO bridge
	localparam logic [3:0] DEVICE_SYSREG = 4'h9;

	//======================================================================
	// System constants
	//======================================================================

	localparam word_t DEVICE_ID = 32'd1;

	// 16 KB of RAM
	localparam word_t RAM_BYTES = 32'h0000_4000;

	localparam int LED_WIDTH = 10;

endpackage
